/* host_bridge_trace.txt */
# op value test_name, value in hex, whole word for W and R, one byte for A and H
# ops A address, W write word, R read word and expect value, H write high half only
A 0010 single_addr
W 1234 single_write
A 0010 single_readdr
R 1234 single_read
A 0011 next_addr
W beef next_write
A 0010 pair_addr
R 1234 pair_first
R beef pair_second
A 00fe block_addr
W a001 block_w0
W a002 block_w1
W a003 block_w2
W a004 block_w3
W a005 block_w4
A 00fe block_read_addr
R a001 block_r0
R a002 block_r1
R a003 block_r2
R a004 block_r3
R a005 block_r4
A 0000 wrap_addr
R a003 wrap_r0
R a004 wrap_r1
A 0030 keep_addr
W 5a5a keep_write
A 0030 pending_addr
H 00ab pending_high
A 0040 new_addr
W c3d4 new_write
A 0040 new_read_addr
R c3d4 new_read
A 0030 old_addr
R 5a5a old_kept
A 0030 turn_addr
H 0077 turn_high
R 5a5a turn_read
W 0102 turn_write
A 0031 turn_check_addr
R 0102 turn_check
A 0011 final_addr
R beef final_read

/* sim.f */
+incdir+.
bus_pkg.sv
mem_pkg.sv
bus_protocol_ctrl.sv
address_pointer.sv
halfword_assembler.sv
readback_serializer.sv
word_ram.sv
host_bridge_top.sv
host_bridge_tb.sv

/* Makefile */
# Verilator flow for the host bridge testbench
VERILATOR  := verilator
TOP        := host_bridge_tb
FILELIST   := sim.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
PASS_TEXT  := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* host_bridge_tb.sv */
// self-checking testbench for the host bridge, replays the trace data through the host handshake
`include "bridge_defs.svh"

module host_bridge_tb;
	logic clock50 = 1'b0;
	logic reset;
	logic [`BRIDGE_HALF_WIDTH-1:0] bus_in;
	logic read;
	logic register_select;
	logic enable;
	logic ack;
	logic [`BRIDGE_HALF_WIDTH-1:0] bus_out;
	logic bus_drive;

	string op_q[$];
	logic [`BRIDGE_WORD_WIDTH-1:0] value_q[$];
	string name_q[$];
	int seed = 7;
	int timeout_cycles = 0;

	host_bridge_top i_dut (
		.clock50         (clock50),
		.reset           (reset),
		.bus_in          (bus_in),
		.read            (read),
		.register_select (register_select),
		.enable          (enable),
		.ack             (ack),
		.bus_out         (bus_out),
		.bus_drive       (bus_drive)
	);

	always #20 clock50 = ~clock50;

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	// bridge must stay quiet between handshakes
	task automatic idle_gap(input string name);
		int gap;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) begin
			@(posedge clock50);
			#2;
			check({name, " idle ack"}, 16'd0, 16'(ack));
			check({name, " idle drive"}, 16'd0, 16'(bus_drive));
		end
	endtask

	// one four-phase handshake, seen is bus_out in the cycle ack rose
	task automatic transfer(input string name, input logic rd, input logic rs,
			input logic [`BRIDGE_HALF_WIDTH-1:0] data,
			output logic [`BRIDGE_HALF_WIDTH-1:0] seen);
		int hold;
		read = rd;
		register_select = rs;
		bus_in = data;
		enable = 1'b1;
		do begin
			@(posedge clock50);
			#2;
			check({name, " drive"}, 16'(rd & ack), 16'(bus_drive));
		end while (!ack);
		seen = bus_out;
		hold = $unsigned($random(seed)) % 2; // host sometimes lingers
		repeat (hold) begin
			@(posedge clock50);
			#2;
			check({name, " ack held"}, 16'd1, 16'(ack));
			check({name, " drive held"}, 16'(rd), 16'(bus_drive));
			if (rd) begin
				check({name, " bus steady"}, 16'(seen), 16'(bus_out));
			end
		end
		enable = 1'b0;
		do begin
			@(posedge clock50);
			#2;
			check({name, " drive"}, 16'(rd & ack), 16'(bus_drive));
		end while (ack);
	endtask

	initial begin
		int fd;
		int count;
		string line;
		string op;
		string name;
		logic [`BRIDGE_WORD_WIDTH-1:0] value;
		logic [`BRIDGE_HALF_WIDTH-1:0] seen;

		reset = 1'b1;
		read = 1'b0;
		register_select = 1'b0;
		enable = 1'b0;
		bus_in = '0;

		fd = $fopen("host_bridge_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file host_bridge_trace.txt");
			abort_run();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				count = $fgets(line, fd);
				count = $sscanf(line, "%s %h %s", op, value, name);
				if (count == 3 && op != "#") begin // comment lines skipped
					op_q.push_back(op);
					value_q.push_back(value);
					name_q.push_back(name);
				end
			end
			$fclose(fd);
		end
		if (op_q.size() == 0) begin
			$display("the trace file holds no operations");
			abort_run();
		end
		timeout_cycles = 40 * op_q.size() + `BRIDGE_RESET_STRETCH + 4;

		repeat (4) begin
			@(posedge clock50);
			#2;
			check("reset ack", 16'd0, 16'(ack));
			check("reset drive", 16'd0, 16'(bus_drive));
		end
		reset = 1'b0;

		// enable already up, must be ignored through the stretch
		enable = 1'b1;
		repeat (`BRIDGE_RESET_STRETCH) begin
			@(posedge clock50);
			#2;
			check("stretch ack", 16'd0, 16'(ack));
			check("stretch drive", 16'd0, 16'(bus_drive));
		end
		transfer("first_after_stretch", 1'b0, 1'b0, '0, seen);

		foreach (op_q[i]) begin
			op = op_q[i];
			value = value_q[i];
			name = name_q[i];
			idle_gap(name);
			if (op == "A") begin
				transfer(name, 1'b0, 1'b0, value[`BRIDGE_HALF_WIDTH-1:0], seen);
			end else if (op == "H") begin
				transfer(name, 1'b0, 1'b1, value[`BRIDGE_HALF_WIDTH-1:0], seen);
			end else if (op == "W") begin
				transfer(name, 1'b0, 1'b1, value[`BRIDGE_WORD_WIDTH-1:`BRIDGE_HALF_WIDTH], seen);
				idle_gap(name);
				transfer(name, 1'b0, 1'b1, value[`BRIDGE_HALF_WIDTH-1:0], seen);
			end else if (op == "R") begin
				transfer(name, 1'b1, 1'b1, '0, seen);
				check({name, " high"}, 16'(value[`BRIDGE_WORD_WIDTH-1:`BRIDGE_HALF_WIDTH]),
					16'(seen));
				idle_gap(name);
				transfer(name, 1'b1, 1'b1, '0, seen);
				check({name, " low"}, 16'(value[`BRIDGE_HALF_WIDTH-1:0]), 16'(seen));
			end else begin
				$display("unknown operation %s in the trace at %s", op, name);
				abort_run();
			end
		end

		repeat (2) @(posedge clock50);
		$display("NO ERRORS");
		$finish;
	end

	// watchdog, armed once the trace length is known
	initial begin
		wait (timeout_cycles != 0);
		repeat (timeout_cycles) @(posedge clock50);
		$display("watchdog ran out, a host handshake hung waiting on ack");
		abort_run();
	end

endmodule

/* host_bridge_top.sv */
// top of the host to memory bridge, wires the handshake control to the ram datapath
`include "bridge_defs.svh"

module host_bridge_top import mem_pkg::*; (
	input  logic clock50,
	input  logic reset,
	input  logic [`BRIDGE_HALF_WIDTH-1:0] bus_in,
	input  logic read,
	input  logic register_select,
	input  logic enable,
	output logic ack,
	output logic [`BRIDGE_HALF_WIDTH-1:0] bus_out,
	output logic bus_drive
);
	logic addr_load;
	logic addr_step;
	logic load_high;
	logic load_low;
	logic read_capture;
	logic read_select_low;
	logic read_active;
	logic wr_en;
	word_u wr_word;
	word_u rd_word;
	addr_t addr;

	bus_protocol_ctrl i_ctrl (
		.clock50         (clock50),
		.reset           (reset),
		.read            (read),
		.register_select (register_select),
		.enable          (enable),
		.ack             (ack),
		.addr_load       (addr_load),
		.addr_step       (addr_step),
		.load_high       (load_high),
		.load_low        (load_low),
		.read_capture    (read_capture),
		.read_select_low (read_select_low),
		.read_active     (read_active)
	);

	address_pointer i_pointer (
		.clock50   (clock50),
		.reset     (reset),
		.addr_load (addr_load),
		.addr_step (addr_step),
		.bus_in    (bus_in),
		.addr      (addr)
	);

	halfword_assembler i_assembler (
		.clock50   (clock50),
		.reset     (reset),
		.load_high (load_high),
		.load_low  (load_low),
		.bus_in    (bus_in),
		.wr_en     (wr_en),
		.wr_word   (wr_word)
	);

	// one address serves both ports
	word_ram i_ram (
		.clock50 (clock50),
		.wr_en   (wr_en),
		.wr_word (wr_word),
		.addr    (addr),
		.rd_word (rd_word)
	);

	readback_serializer i_serializer (
		.clock50         (clock50),
		.reset           (reset),
		.read_capture    (read_capture),
		.read_select_low (read_select_low),
		.read_active     (read_active),
		.rd_word         (rd_word),
		.bus_out         (bus_out),
		.bus_drive       (bus_drive)
	);

endmodule

/* word_ram.sv */
// single clock word ram with registered read, shared address for both ports
`include "bridge_defs.svh"

module word_ram import mem_pkg::*; (
	input  logic clock50,
	input  logic wr_en,
	input  word_u wr_word,
	input  addr_t addr,
	output word_u rd_word
);
	localparam int depth = 1 << `BRIDGE_ADDR_WIDTH;

	logic [`BRIDGE_WORD_WIDTH-1:0] mem [depth];

	always_ff @(posedge clock50) begin
		if (wr_en) begin
			mem[addr] <= wr_word.word;
		end
		rd_word.word <= mem[addr]; // old data on a write cycle
	end

endmodule

/* readback_serializer.sv */
// latches the ram word for a read and puts its halves on the host bus, high half first
`include "bridge_defs.svh"

module readback_serializer import bus_pkg::*, mem_pkg::*; (
	input  logic clock50,
	input  logic reset,
	input  logic read_capture,
	input  logic read_select_low,
	input  logic read_active,
	input  word_u rd_word,
	output half_t bus_out,
	output logic bus_drive
);
	word_u word_q;
	word_u source;
	logic low_q;
	logic show_low;

	always_ff @(posedge clock50) begin
		if (read_capture) begin
			word_q <= rd_word;
		end
	end

	always_ff @(posedge clock50) begin
		if (reset) begin
			low_q <= 1'b0;
			bus_drive <= 1'b0;
		end else begin
			bus_drive <= read_active; // lines up with ack
			if (read_capture) begin
				low_q <= 1'b0;
			end else if (read_select_low) begin
				low_q <= 1'b1;
			end
		end
	end

	// forward the ram output during the capture cycle so the bus is valid with ack
	assign source = read_capture ? rd_word : word_q;
	assign show_low = read_select_low | (low_q & ~read_capture);
	assign bus_out = show_low ? source.half.low : source.half.high;

	// a half is only presented while the pad is turned around
	read_driven: assert property (@(posedge clock50) disable iff (reset)
		(read_capture || read_select_low) |-> bus_drive);

endmodule

/* halfword_assembler.sv */
// builds a ram word from the two written halfwords and issues the write after the low half
`include "bridge_defs.svh"

module halfword_assembler import mem_pkg::*; (
	input  logic clock50,
	input  logic reset,
	input  logic load_high,
	input  logic load_low,
	input  logic [`BRIDGE_HALF_WIDTH-1:0] bus_in,
	output logic wr_en,
	output word_u wr_word
);

	// payload halves, overwritten by the next transfer
	always_ff @(posedge clock50) begin
		if (load_high) begin
			wr_word.half.high <= bus_in;
		end
		if (load_low) begin
			wr_word.half.low <= bus_in;
		end
	end

	always_ff @(posedge clock50) begin
		if (reset) begin
			wr_en <= 1'b0;
		end else begin
			wr_en <= load_low; // word is complete one cycle later
		end
	end

	// every write needs a fresh handshake in front of it
	single_write: assert property (@(posedge clock50) disable iff (reset)
		wr_en |=> !wr_en);

endmodule

/* address_pointer.sv */
// word address register, loaded by an address transfer and stepped after each finished word
`include "bridge_defs.svh"

module address_pointer import mem_pkg::*; (
	input  logic clock50,
	input  logic reset,
	input  logic addr_load,
	input  logic addr_step,
	input  logic [`BRIDGE_HALF_WIDTH-1:0] bus_in,
	output addr_t addr
);

	always_ff @(posedge clock50) begin
		if (reset) begin
			addr <= '0;
		end else if (addr_load) begin
			addr <= bus_in; // whole address in one phase
		end else if (addr_step) begin
			addr <= addr + 1'b1; // wraps at top of memory
		end
	end

endmodule

/* bus_protocol_ctrl.sv */
// host handshake control, holds off after reset, answers enable with ack and strobes the datapath
`include "bridge_defs.svh"

module bus_protocol_ctrl import bus_pkg::*; (
	input  logic clock50,
	input  logic reset,
	input  logic read,            // 0 write, 1 read
	input  logic register_select, // 0 address, 1 data
	input  logic enable,
	output logic ack,
	output logic addr_load,
	output logic addr_step,
	output logic load_high,
	output logic load_low,
	output logic read_capture,
	output logic read_select_low,
	output logic read_active
);
	localparam int stretch_bits = $clog2(`BRIDGE_RESET_STRETCH + 1);

	logic [stretch_bits-1:0] stretch_count;
	logic held;        // still inside the reset stretch
	logic half_flag;   // set once the high half of a word has moved
	logic last_read;   // direction of the previous data transfer
	logic [2:0] step_delay;
	logic step_busy;
	logic ack_next;
	logic start;
	logic same_dir;
	logic low_done;
	phase_t phase;

	// reset stretch counter
	always_ff @(posedge clock50) begin
		if (reset) begin
			stretch_count <= '0;
			held <= 1'b1;
		end else if (held) begin
			stretch_count <= stretch_count + 1'b1;
			if (stretch_count == stretch_bits'(`BRIDGE_RESET_STRETCH - 1)) begin
				held <= 1'b0;
			end
		end
	end

	// a new handshake waits while a pointer step is still settling into the ram read
	assign step_busy = step_delay[1] | step_delay[2];
	assign ack_next = ~held & enable & (ack | ~step_busy);
	assign start = ack_next & ~ack; // first cycle enable is seen
	assign read_active = ack_next & read;

	// a change of direction starts a fresh word
	assign same_dir = half_flag & (last_read == read);

	always_comb begin
		phase = phase_idle;
		if (start) begin
			if (!register_select) begin
				phase = phase_address;
			end else if (read) begin
				phase = same_dir ? phase_read_low : phase_read_high;
			end else begin
				phase = same_dir ? phase_write_low : phase_write_high;
			end
		end
	end

	assign low_done = (phase == phase_write_low) || (phase == phase_read_low);

	always_ff @(posedge clock50) begin
		if (reset) begin
			ack <= 1'b0;
			half_flag <= 1'b0;
			last_read <= 1'b0;
			step_delay <= '0;
			addr_load <= 1'b0;
			load_high <= 1'b0;
			load_low <= 1'b0;
			read_capture <= 1'b0;
			read_select_low <= 1'b0;
		end else begin
			ack <= ack_next;
			// step lands two cycles after the low half, behind the ram write
			step_delay <= {step_delay[1:0], low_done};
			addr_load <= (phase == phase_address);
			load_high <= (phase == phase_write_high);
			load_low <= (phase == phase_write_low);
			read_capture <= (phase == phase_read_high);
			read_select_low <= (phase == phase_read_low);
			if (phase == phase_address) begin
				half_flag <= 1'b0;
			end else if (phase != phase_idle) begin
				half_flag <= ~same_dir; // toggles within one direction
				last_read <= read;
			end
		end
	end

	assign addr_step = step_delay[2];

	// a capture only reads the ram once the pointer has settled
	read_settled: assert property (@(posedge clock50) disable iff (reset)
		read_capture |-> !$past(addr_step));

	// the datapath only ever gets one action per cycle, pointer step included
	one_strobe: assert property (@(posedge clock50) disable iff (reset)
		$onehot0({addr_load, addr_step, load_high, load_low, read_capture, read_select_low}));

endmodule

/* mem_pkg.sv */
// memory side types, the word address and the word seen as ram data or as bus halfwords
`include "bridge_defs.svh"

package mem_pkg;

	typedef logic [`BRIDGE_ADDR_WIDTH-1:0] addr_t;

	// same 16 bits, either as stored in the ram or as the two halves the host moves
	typedef union packed {
		logic [`BRIDGE_WORD_WIDTH-1:0] word;
		struct packed {
			logic [`BRIDGE_HALF_WIDTH-1:0] high; // sent first
			logic [`BRIDGE_HALF_WIDTH-1:0] low;
		} half;
	} word_u;

endpackage

/* bus_pkg.sv */
// host bus types shared by the protocol control and the readback path
`include "bridge_defs.svh"

package bus_pkg;

	// one transfer on the 8-bit host bus
	typedef logic [`BRIDGE_HALF_WIDTH-1:0] half_t;

	// what the current handshake asks the bridge to do
	typedef enum logic [2:0] {
		phase_idle       = 3'd0, // no transfer started this cycle
		phase_address    = 3'd1,
		phase_write_high = 3'd2, // first half of a word
		phase_write_low  = 3'd3,
		phase_read_high  = 3'd4,
		phase_read_low   = 3'd5
	} phase_t;

endpackage

/* bridge_defs.svh */
// bridge widths and reset timing, included by every rtl file and package of the host bridge
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// host bus halfword
`define BRIDGE_HALF_WIDTH 8

// ram word holds two bus halfwords
`define BRIDGE_WORD_WIDTH (2 * `BRIDGE_HALF_WIDTH)

// one address phase carries the whole word address
`define BRIDGE_ADDR_WIDTH `BRIDGE_HALF_WIDTH

// clock50 cycles the bridge stays quiet after reset falls
`define BRIDGE_RESET_STRETCH 16

`endif
